//--- list.f
+incdir+rtl
rtl/xdma_pkg.sv
rtl/xdma_issue_decoder.sv
rtl/xdma_cfg_regfile.sv
rtl/xdma_fe_sequencer.sv
rtl/xdma_xif_ctrl.sv
sim/tb_xdma_fe_model.sv
sim/tb_xdma_xif_ctrl.sv

//--- rtl/xdma_cfg_regfile.sv
// ==========================================================
// DMA config register file.
// Conf, destination, source and length words.
// ==========================================================

`include "xdma_macros.svh"

module xdma_cfg_regfile (
  input  logic                    clk_cfg_g,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    cfg_we_i,
  input  xdma_pkg::xdma_cfg_idx_e cfg_idx_i,
  input  logic [`XDMA_DATA_W-1:0] cfg_wdata_i,
  output logic [`XDMA_DATA_W-1:0] conf_o,
  output logic [`XDMA_DATA_W-1:0] dst_addr_o,
  output logic [`XDMA_DATA_W-1:0] src_addr_o,
  output logic [`XDMA_DATA_W-1:0] len_o,
  output logic                    direction_o
);

  import xdma_pkg::*;

  logic [`XDMA_DATA_W-1:0] conf_q, dst_addr_q, src_addr_q, len_q;
  xdma_conf_payload_t      conf_fields;

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin : cfg_regs
    if (!rst_ni) begin
      conf_q     <= '0;
      dst_addr_q <= '0;
      src_addr_q <= '0;
      len_q      <= '0;
    end else if (clear_i) begin
      conf_q     <= '0;
      dst_addr_q <= '0;
      src_addr_q <= '0;
      len_q      <= '0;
    end else if (cfg_we_i) begin
      case (cfg_idx_i)
        CFG_CONF: conf_q     <= cfg_wdata_i;
        CFG_DST:  dst_addr_q <= cfg_wdata_i;
        CFG_SRC:  src_addr_q <= cfg_wdata_i;
        default:  len_q      <= cfg_wdata_i;
      endcase
    end
  end

  assign conf_o     = conf_q;
  assign dst_addr_o = dst_addr_q;
  assign src_addr_o = src_addr_q;
  assign len_o      = len_q;

  // stored conf is the right-aligned CONF payload.
  assign conf_fields = xdma_conf_payload_t'(conf_q[$bits(xdma_conf_payload_t)-1:0]);
  assign direction_o = conf_fields.direction;

endmodule

//--- rtl/xdma_fe_sequencer.sv
// ==========================================================
// DMA front-end sequencer.
// Programs the front end over the register bus, launches
// the job and polls the next-ID register until it moves on.
// ==========================================================

`include "xdma_macros.svh"

module xdma_fe_sequencer (
  input  logic                    clk_cfg_g,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_req_i,
  input  logic [`XDMA_DATA_W-1:0] conf_i,
  input  logic [`XDMA_DATA_W-1:0] dst_addr_i,
  input  logic [`XDMA_DATA_W-1:0] src_addr_i,
  input  logic [`XDMA_DATA_W-1:0] len_i,
  input  logic                    reg_ready_i,
  input  logic [`XDMA_DATA_W-1:0] reg_rdata_i,
  input  logic                    reg_error_i,
  output logic                    seq_idle_o,
  output logic                    reg_valid_o,
  output logic                    reg_write_o,
  output logic [`XDMA_ADDR_W-1:0] reg_addr_o,
  output logic [`XDMA_DATA_W-1:0] reg_wdata_o,
  output logic                    start_o,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    error_o
);

  import xdma_pkg::*;

  xdma_fe_state_e          state_q, state_d;
  logic [`XDMA_DATA_W-1:0] next_id_q;  // ID returned by the launch read.
  logic                    bus_err;
  logic                    id_err;
  logic                    id_capture;

  // ==========================================================
  // register bus request
  // ==========================================================

  always_comb begin : bus_request
    reg_valid_o = 1'b1;
    reg_write_o = 1'b1;
    reg_addr_o  = `XDMA_REG_NEXT_ID_OFF;
    reg_wdata_o = '0;
    case (state_q)
      WR_CONF: begin
        reg_addr_o  = `XDMA_REG_CONF_OFF;
        reg_wdata_o = conf_i;
      end
      WR_DST: begin
        reg_addr_o  = `XDMA_REG_DST_OFF;
        reg_wdata_o = dst_addr_i;
      end
      WR_SRC: begin
        reg_addr_o  = `XDMA_REG_SRC_OFF;
        reg_wdata_o = src_addr_i;
      end
      WR_LEN: begin
        reg_addr_o  = `XDMA_REG_LEN_OFF;
        reg_wdata_o = len_i;
      end
      LAUNCH, POLL: reg_write_o = 1'b0;  // next-ID reads.
      default: begin
        reg_valid_o = 1'b0;
        reg_write_o = 1'b0;
      end
    endcase
  end

  // ==========================================================
  // errors and state transitions
  // ==========================================================

  assign bus_err = reg_valid_o & reg_error_i;
  // a zero ID means the front end refused the job.
  assign id_err  = (state_q == LAUNCH) & reg_ready_i & (reg_rdata_i == '0);
  assign error_o = bus_err | id_err;

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_req_i) state_d = WR_CONF;
      WR_CONF: if (reg_ready_i) state_d = WR_DST;
      WR_DST:  if (reg_ready_i) state_d = WR_SRC;
      WR_SRC:  if (reg_ready_i) state_d = WR_LEN;
      WR_LEN:  if (reg_ready_i) state_d = LAUNCH;
      LAUNCH:  if (reg_ready_i) state_d = POLL;
      POLL: begin
        if (reg_ready_i && (reg_rdata_i != next_id_q)) begin
          state_d = DONE;  // job retired.
        end
      end
      default: state_d = IDLE;  // DONE lasts one cycle.
    endcase
    if (error_o) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==========================================================
  // launched ID
  // ==========================================================

  assign id_capture = (state_q == LAUNCH) & reg_ready_i & ~error_o;

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin : id_reg
    if (!rst_ni) begin
      next_id_q <= '0;
    end else if (clear_i) begin
      next_id_q <= '0;
    end else if (id_capture) begin
      next_id_q <= reg_rdata_i;
    end
  end

  // ==========================================================
  // status
  // ==========================================================

  assign seq_idle_o = (state_q == IDLE);
  assign start_o    = (state_q == LAUNCH);
  assign busy_o     = (state_q == POLL);
  assign done_o     = (state_q == DONE);

endmodule

//--- rtl/xdma_issue_decoder.sv
// ==========================================================
// DMA issue decoder.
// Accepts CONF and SET from the CPU issue port and turns
// them into config writes or a start request.
// ==========================================================

`include "xdma_macros.svh"

module xdma_issue_decoder (
  input  logic                    issue_valid_i,
  input  xdma_pkg::xdma_instr_u   instr_i,
  input  logic [`XDMA_DATA_W-1:0] rs0_i,
  input  logic                    rs_valid_i,
  input  logic                    seq_idle_i,
  output logic                    issue_ready_o,
  output logic                    accept_o,
  output logic                    cfg_we_o,
  output xdma_pkg::xdma_cfg_idx_e cfg_idx_o,
  output logic [`XDMA_DATA_W-1:0] cfg_wdata_o,
  output logic                    start_req_o
);

  import xdma_pkg::*;

  logic [6:0]    opcode;
  logic [2:0]    func3;
  logic          is_conf;
  logic          is_set;
  logic          set_operand;  // SET form that loads rs0.
  logic          set_start;
  xdma_cfg_idx_e set_idx;
  logic          issue_fire;

  // ==========================================================
  // opcode and func3
  // ==========================================================

  assign opcode  = instr_i.set.opcode;  // same bits in both views.
  assign func3   = instr_i.set.func3;
  assign is_conf = (opcode == `XDMA_CONF_OPCODE);
  assign is_set  = (opcode == `XDMA_SET_OPCODE);

  always_comb begin : set_decode
    set_operand = 1'b0;
    set_start   = 1'b0;
    set_idx     = CFG_DST;
    case (func3)
      `XDMA_SET_DA_F3: begin
        set_operand = 1'b1;
        set_idx     = CFG_DST;
      end
      `XDMA_SET_SA_F3: begin
        set_operand = 1'b1;
        set_idx     = CFG_SRC;
      end
      `XDMA_SET_L_F3: begin
        set_operand = 1'b1;
        set_idx     = CFG_LEN;
      end
      `XDMA_SET_S_F3: set_start = 1'b1;
      // old 2-D forms fall through and are taken as no-ops.
      default: ;
    endcase
  end

  // ==========================================================
  // handshake
  // ==========================================================

  // operand forms also wait for rs0.
  assign issue_ready_o = seq_idle_i &
                         (is_conf | (is_set & (~set_operand | rs_valid_i)));
  assign accept_o      = issue_ready_o;
  assign issue_fire    = issue_valid_i & issue_ready_o;

  // ==========================================================
  // config write and start
  // ==========================================================

  assign cfg_we_o    = issue_fire & (is_conf | (is_set & set_operand));
  assign cfg_idx_o   = is_conf ? CFG_CONF : set_idx;
  assign cfg_wdata_o = is_conf ? `XDMA_DATA_W'(instr_i.conf.payload)  // payload right-aligned.
                               : rs0_i;
  assign start_req_o = issue_fire & is_set & set_start;

endmodule

//--- rtl/xdma_macros.svh
// ==========================================================
// DMA issue controller macros.
// Opcodes, func3 codes, widths and front-end register map.
// ==========================================================

`ifndef XDMA_MACROS_SVH
`define XDMA_MACROS_SVH

// ==========================================================
// widths
// ==========================================================
`define XDMA_DATA_W 32  // register and operand width.
`define XDMA_ADDR_W 32  // register bus address width.

// ==========================================================
// custom instruction encodings
// ==========================================================
`define XDMA_CONF_OPCODE 7'b1011011  // custom-2 space.
`define XDMA_SET_OPCODE  7'b1111011  // custom-3 space.

// SET sub-operations, selected by func3.
`define XDMA_SET_DA_F3 3'd0
`define XDMA_SET_SA_F3 3'd1
`define XDMA_SET_L_F3  3'd2
`define XDMA_SET_S_F3  3'd7

// ==========================================================
// front-end register offsets
// ==========================================================
`define XDMA_REG_CONF_OFF    `XDMA_ADDR_W'('h000)
`define XDMA_REG_DST_OFF     `XDMA_ADDR_W'('h008)
`define XDMA_REG_SRC_OFF     `XDMA_ADDR_W'('h010)
`define XDMA_REG_LEN_OFF     `XDMA_ADDR_W'('h018)
`define XDMA_REG_NEXT_ID_OFF `XDMA_ADDR_W'('h044)  // read launches a job.

`endif

//--- rtl/xdma_pkg.sv
// ==========================================================
// DMA issue controller types.
// Instruction formats, config register index, FSM states.
// ==========================================================

package xdma_pkg;

  // ==========================================================
  // instruction word
  // ==========================================================

  // option payload of CONF, bits 31:7 of the instruction.
  typedef struct packed {
    logic        direction;        // 1 selects the reverse path.
    logic        decouple_r_aw;
    logic        decouple_r_w;
    logic        src_reduce;
    logic        dst_reduce;
    logic [2:0]  src_max_log_len;
    logic [2:0]  dst_max_log_len;
    logic [13:0] reserved;
  } xdma_conf_payload_t;

  typedef struct packed {
    xdma_conf_payload_t payload;
    logic [6:0]         opcode;
  } xdma_conf_instr_t;

  // standard R-type layout.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] func3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } xdma_set_instr_t;

  // one issued word, seen either as CONF or as SET.
  // the opcode sits in the low 7 bits of both views.
  typedef union packed {
    xdma_conf_instr_t conf;
    xdma_set_instr_t  set;
  } xdma_instr_u;

  // ==========================================================
  // config registers and sequencer
  // ==========================================================

  typedef enum logic [1:0] {
    CFG_CONF = 2'd0,
    CFG_DST  = 2'd1,
    CFG_SRC  = 2'd2,
    CFG_LEN  = 2'd3
  } xdma_cfg_idx_e;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    WR_CONF = 3'd1,
    WR_DST  = 3'd2,
    WR_SRC  = 3'd3,
    WR_LEN  = 3'd4,
    LAUNCH  = 3'd5,  // next-ID read starts the job.
    POLL    = 3'd6,
    DONE    = 3'd7
  } xdma_fe_state_e;

endpackage

//--- rtl/xdma_xif_ctrl.sv
// ==========================================================
// DMA coprocessor controller top.
// Issue decoder, config registers and front-end sequencer.
// ==========================================================

`include "xdma_macros.svh"

module xdma_xif_ctrl (
  input  logic                    clk_cfg_g,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  // CPU issue port.
  input  logic                    issue_valid_i,
  input  xdma_pkg::xdma_instr_u   instr_i,
  input  logic [`XDMA_DATA_W-1:0] rs0_i,
  input  logic                    rs_valid_i,
  output logic                    issue_ready_o,
  output logic                    accept_o,
  // front-end register bus.
  output logic                    reg_valid_o,
  output logic                    reg_write_o,
  output logic [`XDMA_ADDR_W-1:0] reg_addr_o,
  output logic [`XDMA_DATA_W-1:0] reg_wdata_o,
  input  logic                    reg_ready_i,
  input  logic [`XDMA_DATA_W-1:0] reg_rdata_i,
  input  logic                    reg_error_i,
  // transfer status.
  output logic                    direction_o,
  output logic                    start_o,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    error_o
);

  import xdma_pkg::*;

  logic                    cfg_we;
  xdma_cfg_idx_e           cfg_idx;
  logic [`XDMA_DATA_W-1:0] cfg_wdata;
  logic                    start_req;
  logic                    seq_idle;
  logic [`XDMA_DATA_W-1:0] conf, dst_addr, src_addr, len;

  xdma_issue_decoder u_issue_decoder (
    .issue_valid_i (issue_valid_i),
    .instr_i       (instr_i),
    .rs0_i         (rs0_i),
    .rs_valid_i    (rs_valid_i),
    .seq_idle_i    (seq_idle),
    .issue_ready_o (issue_ready_o),
    .accept_o      (accept_o),
    .cfg_we_o      (cfg_we),
    .cfg_idx_o     (cfg_idx),
    .cfg_wdata_o   (cfg_wdata),
    .start_req_o   (start_req)
  );

  xdma_cfg_regfile u_cfg_regfile (
    .clk_cfg_g   (clk_cfg_g),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .cfg_we_i    (cfg_we),
    .cfg_idx_i   (cfg_idx),
    .cfg_wdata_i (cfg_wdata),
    .conf_o      (conf),
    .dst_addr_o  (dst_addr),
    .src_addr_o  (src_addr),
    .len_o       (len),
    .direction_o (direction_o)
  );

  xdma_fe_sequencer u_fe_sequencer (
    .clk_cfg_g   (clk_cfg_g),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .start_req_i (start_req),
    .conf_i      (conf),
    .dst_addr_i  (dst_addr),
    .src_addr_i  (src_addr),
    .len_i       (len),
    .reg_ready_i (reg_ready_i),
    .reg_rdata_i (reg_rdata_i),
    .reg_error_i (reg_error_i),
    .seq_idle_o  (seq_idle),
    .reg_valid_o (reg_valid_o),
    .reg_write_o (reg_write_o),
    .reg_addr_o  (reg_addr_o),
    .reg_wdata_o (reg_wdata_o),
    .start_o     (start_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .error_o     (error_o)
  );

endmodule

//--- sim/tb_xdma_fe_model.sv
// ==========================================================
// Behavioral DMA front-end register slave.
// Random ready delays, a write log and scripted next-ID reads.
// ==========================================================

`include "xdma_macros.svh"

module tb_xdma_fe_model (
  input  logic                    clk_cfg_g,
  input  logic                    rst_ni,
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  logic [`XDMA_ADDR_W-1:0] reg_addr_i,
  input  logic [`XDMA_DATA_W-1:0] reg_wdata_i,
  output logic                    reg_ready_o,
  output logic [`XDMA_DATA_W-1:0] reg_rdata_o,
  output logic                    reg_error_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`XDMA_ADDR_W-1:0] wr_addr_q[$];  // completed writes, in order.
  logic [`XDMA_DATA_W-1:0] wr_data_q[$];
  logic [`XDMA_DATA_W-1:0] id_q[$];       // next-ID script, last entry is held.
  logic                    err_en = 1'b0;
  logic [`XDMA_ADDR_W-1:0] err_addr = '0;
  integer                  seed = 32'hb61d;
  int unsigned             wait_cnt;

  task automatic reset_log();
    wr_addr_q.delete();
    wr_data_q.delete();
  endtask

  task automatic clear_ids();
    id_q.delete();
  endtask

  task automatic load_id(input logic [`XDMA_DATA_W-1:0] id);
    id_q.push_back(id);
  endtask

  // flags an error on the response to one address.
  task automatic set_error(input logic en, input logic [`XDMA_ADDR_W-1:0] addr);
    err_en   = en;
    err_addr = addr;
  endtask

  always @(posedge clk_cfg_g or negedge rst_ni) begin : responder
    if (!rst_ni) begin
      reg_ready_o <= 1'b0;
      reg_rdata_o <= '0;
      reg_error_o <= 1'b0;
      wait_cnt    <= 0;
    end else if (reg_ready_o) begin
      // request completes on this edge.
      if (reg_valid_i && reg_write_i && !reg_error_o) begin
        wr_addr_q.push_back(reg_addr_i);
        wr_data_q.push_back(reg_wdata_i);
      end
      reg_ready_o <= 1'b0;
      reg_error_o <= 1'b0;
      wait_cnt    <= $unsigned($random(seed)) % 3;
    end else if (reg_valid_i) begin
      if (wait_cnt == 0) begin
        reg_ready_o <= 1'b1;
        reg_error_o <= err_en && (reg_addr_i == err_addr);
        if (!reg_write_i) begin
          reg_rdata_o <= (id_q.size() > 0) ? id_q[0] : '0;  // empty script reads zero.
          if (id_q.size() > 1) void'(id_q.pop_front());
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

//--- sim/tb_xdma_xif_ctrl.sv
// ==========================================================
// Testbench for the DMA coprocessor controller.
// Directed tests over the issue port and the front-end bus.
// ==========================================================

`include "xdma_macros.svh"

module tb_xdma_xif_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  import xdma_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int WAIT_DONE      = 0;
  localparam int WAIT_ERROR     = 1;
  localparam int WAIT_BUSY      = 2;
  localparam int WAIT_START     = 3;

  logic                    clk_cfg_g;
  logic                    rst_ni;
  logic                    clear_i;
  logic                    issue_valid_i;
  xdma_instr_u             instr_i;
  logic [`XDMA_DATA_W-1:0] rs0_i;
  logic                    rs_valid_i;
  logic                    issue_ready_o;
  logic                    accept_o;
  logic                    reg_valid_o;
  logic                    reg_write_o;
  logic [`XDMA_ADDR_W-1:0] reg_addr_o;
  logic [`XDMA_DATA_W-1:0] reg_wdata_o;
  logic                    reg_ready_i;
  logic [`XDMA_DATA_W-1:0] reg_rdata_i;
  logic                    reg_error_i;
  logic                    direction_o;
  logic                    start_o;
  logic                    busy_o;
  logic                    done_o;
  logic                    error_o;
  int                      done_pulses;  // done_o cycles since the transfer was programmed.

  xdma_xif_ctrl i_dut (.*);

  tb_xdma_fe_model i_model (
    .clk_cfg_g   (clk_cfg_g),
    .rst_ni      (rst_ni),
    .reg_valid_i (reg_valid_o),
    .reg_write_i (reg_write_o),
    .reg_addr_i  (reg_addr_o),
    .reg_wdata_i (reg_wdata_o),
    .reg_ready_o (reg_ready_i),
    .reg_rdata_o (reg_rdata_i),
    .reg_error_o (reg_error_i)
  );

  always #20 clk_cfg_g = ~clk_cfg_g;

  // every cycle with done_o high counts, whatever the test is doing.
  always @(negedge clk_cfg_g) begin : done_monitor
    if (done_o) begin
      done_pulses++;
    end
  end

  // ==========================================================
  // checking and waiting
  // ==========================================================

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH at %0t ns: %s got 0x%08h, expected 0x%08h",
                                  $time, name, got, exp));
    end
  endtask

  function automatic logic status_bit(input int kind);
    case (kind)
      WAIT_DONE:  return done_o;
      WAIT_ERROR: return error_o;
      WAIT_START: return start_o;
      default:    return busy_o;
    endcase
  endfunction

  // samples on the falling edge until the selected status is high.
  task automatic wait_status(input int kind, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_cfg_g);
    while (!status_bit(kind)) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("timeout: %s never went high", what));
      end
      cycles++;
      @(negedge clk_cfg_g);
    end
  endtask

  // ==========================================================
  // stimulus helpers
  // ==========================================================

  function automatic xdma_instr_u set_word(input logic [2:0] f3);
    xdma_instr_u w;
    w            = '0;
    w.set.opcode = `XDMA_SET_OPCODE;
    w.set.func3  = f3;
    w.set.rs1    = 5'd10;
    return w;
  endfunction

  function automatic xdma_instr_u conf_word(input logic dir);
    return xdma_instr_u'({dir, 24'h5a_c300, `XDMA_CONF_OPCODE});
  endfunction

  task automatic issue(input xdma_instr_u instr, input logic [31:0] rs0, input logic rs_valid,
                       input logic exp_accept, input string name);
    @(posedge clk_cfg_g);
    issue_valid_i <= 1'b1;
    instr_i       <= instr;
    rs0_i         <= rs0;
    rs_valid_i    <= rs_valid;
    @(negedge clk_cfg_g);
    check_eq({name, " accept_o"}, accept_o, exp_accept);
    check_eq({name, " issue_ready_o"}, issue_ready_o, exp_accept);
    @(posedge clk_cfg_g);  // taken on this edge when accepted.
    issue_valid_i <= 1'b0;
    rs_valid_i    <= 1'b0;
  endtask

  task automatic program_transfer(input xdma_instr_u conf, input logic [31:0] dst,
                                  input logic [31:0] src, input logic [31:0] len);
    i_model.reset_log();
    done_pulses = 0;
    issue(conf, 32'h0, 1'b0, 1'b1, "CONF");
    issue(set_word(`XDMA_SET_DA_F3), dst, 1'b1, 1'b1, "SET dst");
    issue(set_word(`XDMA_SET_SA_F3), src, 1'b1, 1'b1, "SET src");
    issue(set_word(`XDMA_SET_L_F3), len, 1'b1, 1'b1, "SET len");
    issue(set_word(`XDMA_SET_S_F3), 32'h0, 1'b0, 1'b1, "SET start");
  endtask

  task automatic check_write(input int idx, input logic [31:0] addr, input logic [31:0] data);
    check_eq($sformatf("write %0d address", idx), i_model.wr_addr_q[idx], addr);
    check_eq($sformatf("write %0d data", idx), i_model.wr_data_q[idx], data);
  endtask

  // ==========================================================
  // directed tests
  // ==========================================================

  task automatic test_reset_values();
    @(negedge clk_cfg_g);
    check_eq("direction_o", direction_o, 1'b0);
    check_eq("reg_valid_o", reg_valid_o, 1'b0);
    check_eq("start_o", start_o, 1'b0);
    check_eq("busy_o", busy_o, 1'b0);
    check_eq("done_o", done_o, 1'b0);
    check_eq("error_o", error_o, 1'b0);
  endtask

  task automatic test_full_transfer();
    xdma_instr_u conf;
    conf = conf_word(1'b1);
    i_model.clear_ids();
    i_model.load_id(32'd5);
    i_model.load_id(32'd5);
    i_model.load_id(32'd6);
    program_transfer(conf, 32'h8000_1000, 32'h4000_0200, 32'h0000_0100);
    wait_status(WAIT_START, "start_o on launch read");
    check_eq("reg_valid_o during launch", reg_valid_o, 1'b1);
    check_eq("reg_write_o during launch", reg_write_o, 1'b0);
    check_eq("reg_addr_o during launch", reg_addr_o, `XDMA_REG_NEXT_ID_OFF);
    check_eq("busy_o during launch", busy_o, 1'b0);
    wait_status(WAIT_BUSY, "busy_o after launch");
    check_eq("start_o during polling", start_o, 1'b0);
    check_eq("reg_write_o during polling", reg_write_o, 1'b0);
    wait_status(WAIT_DONE, "done_o after full transfer");
    @(negedge clk_cfg_g);
    check_eq("done_o one cycle later", done_o, 1'b0);
    check_eq("done_o pulse count", done_pulses, 1);
    check_eq("write count", i_model.wr_addr_q.size(), 4);
    check_write(0, `XDMA_REG_CONF_OFF, 32'(conf) >> 7);
    check_write(1, `XDMA_REG_DST_OFF, 32'h8000_1000);
    check_write(2, `XDMA_REG_SRC_OFF, 32'h4000_0200);
    check_write(3, `XDMA_REG_LEN_OFF, 32'h0000_0100);
    check_eq("direction_o", direction_o, conf[31]);
  endtask

  task automatic test_launch_error();
    i_model.clear_ids();
    i_model.load_id(32'd0);  // front end refuses the job.
    program_transfer(conf_word(1'b0), 32'h1000, 32'h2000, 32'h40);
    wait_status(WAIT_ERROR, "error_o on zero launch ID");
    @(negedge clk_cfg_g);
    check_eq("error_o one cycle later", error_o, 1'b0);
    check_eq("done_o pulse count", done_pulses, 0);
    check_eq("done_o", done_o, 1'b0);
    check_eq("reg_valid_o back in idle", reg_valid_o, 1'b0);
  endtask

  task automatic test_bus_error();
    i_model.clear_ids();
    i_model.load_id(32'd7);
    i_model.load_id(32'd8);
    i_model.set_error(1'b1, `XDMA_REG_SRC_OFF);
    program_transfer(conf_word(1'b0), 32'h3000, 32'h5000, 32'h80);
    wait_status(WAIT_ERROR, "error_o on source write");
    @(negedge clk_cfg_g);
    i_model.set_error(1'b0, '0);
    check_eq("error_o one cycle later", error_o, 1'b0);
    check_eq("reg_valid_o back in idle", reg_valid_o, 1'b0);
    check_eq("write count", i_model.wr_addr_q.size(), 2);  // conf and dst only.
    check_write(1, `XDMA_REG_DST_OFF, 32'h3000);
  endtask

  task automatic test_issue_rules();
    xdma_instr_u bad;
    bad = xdma_instr_u'({25'h12345, 7'b0110011});  // plain R-type opcode outside custom space.
    issue(bad, 32'h0, 1'b1, 1'b0, "unknown opcode");
    issue(set_word(`XDMA_SET_DA_F3), 32'hdead_0000, 1'b0, 1'b0, "SET dst without rs");
    i_model.clear_ids();
    for (int i = 0; i < 5; i++) i_model.load_id(32'd9);
    i_model.load_id(32'd10);
    program_transfer(conf_word(1'b0), 32'h6000, 32'h7000, 32'h20);
    wait_status(WAIT_BUSY, "busy_o during polling");
    issue(conf_word(1'b1), 32'h0, 1'b0, 1'b0, "CONF while busy");
    issue(set_word(`XDMA_SET_S_F3), 32'h0, 1'b0, 1'b0, "SET start while busy");
    @(negedge clk_cfg_g);
    check_eq("busy_o after rejected issues", busy_o, 1'b1);
    wait_status(WAIT_DONE, "done_o after polling");
  endtask

  task automatic test_clear();
    i_model.clear_ids();
    i_model.load_id(32'd3);  // ID never moves, so polling goes on.
    program_transfer(conf_word(1'b1), 32'h9000, 32'ha000, 32'h10);
    wait_status(WAIT_BUSY, "busy_o before clear");
    check_eq("direction_o before clear", direction_o, 1'b1);
    @(posedge clk_cfg_g);
    clear_i <= 1'b1;
    @(posedge clk_cfg_g);
    clear_i <= 1'b0;
    @(negedge clk_cfg_g);
    check_eq("busy_o after clear", busy_o, 1'b0);
    check_eq("reg_valid_o after clear", reg_valid_o, 1'b0);
    check_eq("direction_o after clear", direction_o, 1'b0);
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================

  initial begin : main
    clk_cfg_g     = 1'b0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    issue_valid_i = 1'b0;
    instr_i       = '0;
    rs0_i         = '0;
    rs_valid_i    = 1'b0;
    done_pulses   = 0;
    repeat (8) @(posedge clk_cfg_g);
    rst_ni <= 1'b1;
    test_reset_values();
    test_full_transfer();
    test_launch_error();
    test_bus_error();
    test_issue_rules();
    test_clear();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
